//--- uart_bank.f
design/uart_bank_pkg.sv
design/baud_tick_gen.sv
design/tx_dispatch.sv
design/uart_lane.sv
design/rx_collector.sv
design/uart_bank.sv
testbench/tb_uart_bank.sv

//--- run.sh
#!/bin/sh
# Build the bank testbench with Verilator, run it and search the log for the fail message
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_uart_bank -f uart_bank.f &&
{ ./obj_dir/Vtb_uart_bank > sim.log 2>&1; cat sim.log; } &&
! grep -q "FAIL: see errors above" sim.log &&
grep -q "PASS: all tests" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- testbench/tb_uart_bank.sv
// Loopback testbench for the UART bank with reference queues and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bank import uart_bank_pkg::*; ();

  localparam int NEW_DIV     = 3;
  localparam int FRAME_LIMIT = 4000;

  logic       clk;
  logic       rst_n;
  logic       set_clock_div;
  clock_div_t user_clock_div;
  logic       tx_start;
  tx_cmd_t    tx_cmd;
  lane_mask_t rx;
  lane_mask_t tx;
  lane_mask_t tx_busy;
  lane_mask_t rx_busy;
  logic       tx_reject;
  logic       rx_valid;
  rx_event_t  rx_event;

  // Forces a lane's line low, used to break a stop bit
  lane_mask_t corrupt;
  // Predicted events, one queue per lane
  rx_event_t  exp_q [NUM_LANES][$];
  int         seed = 32'h2678e0a5;
  int         errors = 0;
  int         lane;
  int         cycles;
  uart_byte_t data;

  uart_bank UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .set_clock_div  (set_clock_div),
    .user_clock_div (user_clock_div),
    .tx_start       (tx_start),
    .tx_cmd         (tx_cmd),
    .rx             (rx),
    .tx             (tx),
    .tx_busy        (tx_busy),
    .rx_busy        (rx_busy),
    .tx_reject      (tx_reject),
    .rx_valid       (rx_valid),
    .rx_event       (rx_event)
  );

  // Loopback through the corrupt mask
  assign rx = tx & ~corrupt;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    errors++;
    $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name, expected, got);
    stop_with_failure();
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic check_idle_outputs();
    assert (tx == '1) else value_error("tx", 32'(4'hf), 32'(tx));
    assert (tx_busy == '0) else value_error("tx_busy", 0, 32'(tx_busy));
    assert (rx_busy == '0) else value_error("rx_busy", 0, 32'(rx_busy));
    assert (rx_valid == 1'b0) else value_error("rx_valid", 0, 32'(rx_valid));
    assert (tx_reject == 1'b0) else value_error("tx_reject", 0, 32'(tx_reject));
  endtask

  task automatic expect_event(input int ln, input uart_byte_t b, input logic fe);
    rx_event_t ev;
    ev.lane        = lane_idx_t'(ln);
    ev.data        = b;
    ev.frame_error = fe;
    ev.overrun     = 1'b0;
    exp_q[ln].push_back(ev);
  endtask

  // One command on an idle lane, must be accepted
  task automatic send_byte(input int ln, input uart_byte_t b, input logic fe);
    @(negedge clk);
    tx_start    = 1'b1;
    tx_cmd.lane = lane_idx_t'(ln);
    tx_cmd.data = b;
    expect_event(ln, b, fe);
    @(negedge clk);
    tx_start = 1'b0;
    assert (tx_reject == 1'b0) else value_error("tx_reject", 0, 32'(tx_reject));
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < NUM_LANES; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic wait_tx_low(input int ln);
    int n;
    n = 0;
    while (tx[ln] !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > FRAME_LIMIT) report_problem("start bit never appeared on tx");
    end
  endtask

  // Counts cycles until the frame's busy level drops
  task automatic wait_tx_done(input int ln, output int count);
    count = 0;
    while (tx_busy[ln] !== 1'b0) begin
      @(negedge clk);
      count++;
      if (count > FRAME_LIMIT) report_problem("transmitter stayed busy too long");
    end
  endtask

  // All predicted events seen and every lane idle
  task automatic wait_bank_quiet();
    int n;
    n = 0;
    while (outstanding() != 0 || tx_busy != '0 || rx_busy != '0 || rx_valid) begin
      @(negedge clk);
      n++;
      if (n > 3 * FRAME_LIMIT) report_problem("expected receive events never arrived");
    end
  endtask

  // Event checker, outputs are stable at the falling edge
  always @(negedge clk) begin : check_events
    rx_event_t exp_ev;
    if (rst_n && rx_valid) begin
      if (exp_q[rx_event.lane].size() == 0) begin
        report_problem("receive event arrived with no byte outstanding on its lane");
      end else begin
        exp_ev = exp_q[rx_event.lane].pop_front();
        assert (rx_event.data == exp_ev.data)
          else value_error("rx_event.data", 32'(exp_ev.data), 32'(rx_event.data));
        assert (rx_event.frame_error == exp_ev.frame_error)
          else value_error("rx_event.frame_error", 32'(exp_ev.frame_error),
                           32'(rx_event.frame_error));
        assert (rx_event.overrun == exp_ev.overrun)
          else value_error("rx_event.overrun", 32'(exp_ev.overrun), 32'(rx_event.overrun));
      end
    end
  end

  initial begin
    rst_n          = 1'b0;
    set_clock_div  = 1'b0;
    user_clock_div = '0;
    tx_start       = 1'b0;
    tx_cmd         = '0;
    corrupt        = '0;

    // Reset state, during and after
    repeat (16) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    // Each lane in turn, then a few random lanes
    for (int l = 0; l < NUM_LANES; l++) begin
      send_byte(l, uart_byte_t'($random(seed)), 1'b0);
      wait_bank_quiet();
    end
    repeat (4) begin
      lane = $random(seed) & (NUM_LANES - 1);
      send_byte(lane, uart_byte_t'($random(seed)), 1'b0);
      wait_bank_quiet();
    end

    // All lanes back to back
    for (int l = 0; l < NUM_LANES; l++) begin
      data = uart_byte_t'($random(seed));
      @(negedge clk);
      tx_start    = 1'b1;
      tx_cmd.lane = lane_idx_t'(l);
      tx_cmd.data = data;
      expect_event(l, data, 1'b0);
    end
    // Lane 2 is busy by now, no event predicted
    @(negedge clk);
    tx_cmd.lane = lane_idx_t'(2);
    tx_cmd.data = 8'ha5;
    @(negedge clk);
    tx_start = 1'b0;
    assert (tx_reject == 1'b1) else value_error("tx_reject", 1, 32'(tx_reject));
    wait_bank_quiet();

    // Stop bit of lane 1 held low
    data = uart_byte_t'($random(seed));
    send_byte(1, data, 1'b1);
    wait_tx_low(1);
    // Past data bit 7, before the mid-stop sample
    repeat ((9 * OVERSAMPLE + 4) * DEFAULT_CLOCK_DIV) @(negedge clk);
    corrupt[1] = 1'b1;
    wait_tx_done(1, cycles);
    corrupt = '0;
    wait_bank_quiet();

    // New divider, frame length follows it
    @(negedge clk);
    set_clock_div  = 1'b1;
    user_clock_div = clock_div_t'(NEW_DIV);
    @(negedge clk);
    set_clock_div = 1'b0;
    @(negedge clk);
    for (int l = 0; l < NUM_LANES; l++) begin
      send_byte(l, uart_byte_t'($random(seed)), 1'b0);
      wait_tx_low(l);
      wait_tx_done(l, cycles);
      // Ten bits of 16 ticks, start phase moves it by one divider period
      assert (cycles >= 10 * OVERSAMPLE * NEW_DIV - NEW_DIV &&
              cycles <= 10 * OVERSAMPLE * NEW_DIV + NEW_DIV)
        else value_error("frame_cycles", 10 * OVERSAMPLE * NEW_DIV, cycles);
      wait_bank_quiet();
    end

    repeat (10) @(negedge clk);
    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

//--- design/uart_bank.sv
// Four-lane UART bank top level with shared divider, dispatcher and receive collector
`timescale 1ns/1ps
`default_nettype none

module uart_bank import uart_bank_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       set_clock_div,
  input  clock_div_t user_clock_div,
  input  logic       tx_start,
  input  tx_cmd_t    tx_cmd,
  input  lane_mask_t rx,
  output lane_mask_t tx,
  output lane_mask_t tx_busy,
  output lane_mask_t rx_busy,
  output logic       tx_reject,
  output logic       rx_valid,
  output rx_event_t  rx_event
);

  logic       tick;
  logic       restart;
  lane_mask_t lane_start;
  uart_byte_t lane_data;
  lane_mask_t rx_done;
  rx_result_t rx_result [NUM_LANES];

  // One tick source for every lane
  baud_tick_gen u_baud (
    .clk            (clk),
    .rst_n          (rst_n),
    .set_clock_div  (set_clock_div),
    .user_clock_div (user_clock_div),
    .tick           (tick),
    .restart        (restart)
  );

  tx_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx_start   (tx_start),
    .tx_cmd     (tx_cmd),
    .tx_busy    (tx_busy),
    .lane_start (lane_start),
    .lane_data  (lane_data),
    .tx_reject  (tx_reject)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    uart_lane u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .tick    (tick),
      .restart (restart),
      .start   (lane_start[i]),
      .data_in (lane_data),
      .tx      (tx[i]),
      .tx_busy (tx_busy[i]),
      .rx      (rx[i]),
      .rx_busy (rx_busy[i]),
      .rx_done (rx_done[i]),
      .result  (rx_result[i])
    );
  end

  rx_collector u_collector (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_done   (rx_done),
    .rx_result (rx_result),
    .rx_valid  (rx_valid),
    .rx_event  (rx_event)
  );

endmodule

`default_nettype wire

//--- design/rx_collector.sv
// Per-lane receive result slots with overrun marking and round-robin event output
`timescale 1ns/1ps
`default_nettype none

module rx_collector import uart_bank_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  lane_mask_t rx_done,
  input  rx_result_t rx_result [NUM_LANES],
  output logic       rx_valid,
  output rx_event_t  rx_event
);

  rx_result_t slot [NUM_LANES];
  lane_mask_t pend;
  lane_mask_t ovr;
  lane_mask_t eff_pend;
  lane_mask_t eff_ovr;
  lane_mask_t grant;
  lane_idx_t  last_lane;
  lane_idx_t  sel_lane;
  logic       sel_valid;
  rx_result_t sel_result;

  // Fresh results compete in the same cycle they arrive
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      eff_pend[i] = pend[i] | rx_done[i];
      eff_ovr[i]  = rx_done[i] ? pend[i] : ovr[i];
    end
  end

  // Search starts one past the lane served last
  always_comb begin
    lane_idx_t cand;
    sel_valid = 1'b0;
    sel_lane  = last_lane;
    for (int k = 1; k <= NUM_LANES; k++) begin
      cand = lane_idx_t'(last_lane + k);
      if (!sel_valid && eff_pend[cand]) begin
        sel_valid = 1'b1;
        sel_lane  = cand;
      end
    end
  end

  assign grant      = sel_valid ? (lane_mask_t'(1) << sel_lane) : '0;
  assign sel_result = rx_done[sel_lane] ? rx_result[sel_lane] : slot[sel_lane];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend      <= '0;
      ovr       <= '0;
      rx_valid  <= 1'b0;
      last_lane <= lane_idx_t'(NUM_LANES - 1);
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (grant[i]) begin
          pend[i] <= 1'b0;
          ovr[i]  <= 1'b0;
        end else if (rx_done[i]) begin
          // Newer result replaces an unread one
          pend[i] <= 1'b1;
          ovr[i]  <= pend[i];
        end
      end
      rx_valid <= sel_valid;
      if (sel_valid) begin
        last_lane <= sel_lane;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (rx_done[i] && !grant[i]) begin
        slot[i] <= rx_result[i];
      end
    end
    if (sel_valid) begin
      rx_event.lane        <= sel_lane;
      rx_event.data        <= sel_result.data;
      rx_event.frame_error <= sel_result.frame_error;
      rx_event.overrun     <= eff_ovr[sel_lane];
    end
  end

  // A lane just served yields to any other waiting lane
  a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
    (sel_valid && (eff_pend & ~grant) != '0) |=> (grant & $past(grant)) == '0);

endmodule

`default_nettype wire

//--- design/uart_lane.sv
// Single 8N1 UART lane with transmit and receive state machines on the shared tick
`timescale 1ns/1ps
`default_nettype none

module uart_lane import uart_bank_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tick,
  input  logic       restart,
  input  logic       start,
  input  uart_byte_t data_in,
  output logic       tx,
  output logic       tx_busy,
  input  logic       rx,
  output logic       rx_busy,
  output logic       rx_done,
  output rx_result_t result
);

  tx_state_e  tx_state;
  tick_cnt_t  tx_tick_cnt;
  bit_cnt_t   tx_bit_cnt;
  uart_byte_t tx_shift;
  logic       tx_bit_end;
  logic       tx_shift_en;

  rx_state_e  rx_state;
  tick_cnt_t  rx_tick_cnt;
  bit_cnt_t   rx_bit_cnt;
  uart_byte_t rx_shift;
  logic       rx_prev;
  logic       rx_fall;
  logic       rx_half;
  logic       rx_bit_end;

  assign tx_busy = (tx_state != TX_IDLE);
  assign rx_busy = (rx_state != RX_IDLE);

  // Last tick of a bit period
  assign tx_bit_end  = tick && (tx_tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));
  // Move to the next data bit at the end of start and of each data bit
  assign tx_shift_en = tx_bit_end && (tx_state == TX_START || tx_state == TX_DATA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state    <= TX_IDLE;
      tx          <= 1'b1;
      tx_tick_cnt <= '0;
      tx_bit_cnt  <= '0;
    end else if (restart) begin
      // Divider change drops the frame in flight
      tx_state    <= TX_IDLE;
      tx          <= 1'b1;
      tx_tick_cnt <= '0;
      tx_bit_cnt  <= '0;
    end else begin
      if (tx_state == TX_IDLE) begin
        tx_tick_cnt <= '0;
      end else if (tick) begin
        tx_tick_cnt <= tx_bit_end ? '0 : tx_tick_cnt + 1'b1;
      end
      case (tx_state)
        TX_IDLE: begin
          // Start bit goes out right away
          if (start) begin
            tx       <= 1'b0;
            tx_state <= TX_START;
          end
        end
        TX_START: begin
          if (tx_bit_end) begin
            tx         <= tx_shift[0];
            tx_bit_cnt <= '0;
            tx_state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (tx_bit_end) begin
            if (tx_bit_cnt == bit_cnt_t'(7)) begin
              tx         <= 1'b1;
              tx_bit_cnt <= '0;
              tx_state   <= TX_STOP;
            end else begin
              tx         <= tx_shift[0];
              tx_bit_cnt <= tx_bit_cnt + 1'b1;
            end
          end
        end
        TX_STOP: begin
          // Bit counter reused for stop periods
          if (tx_bit_end) begin
            if (tx_bit_cnt == bit_cnt_t'(STOP_BITS - 1)) begin
              tx_state <= TX_IDLE;
            end else begin
              tx_bit_cnt <= tx_bit_cnt + 1'b1;
            end
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  // LSB first shift register
  always_ff @(posedge clk) begin
    if (tx_state == TX_IDLE && start) begin
      tx_shift <= data_in;
    end else if (tx_shift_en) begin
      tx_shift <= {1'b0, tx_shift[7:1]};
    end
  end

  assign rx_fall    = rx_prev && !rx;
  assign rx_half    = tick && (rx_tick_cnt == tick_cnt_t'(HALF_BIT - 1));
  assign rx_bit_end = tick && (rx_tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_state    <= RX_IDLE;
      rx_tick_cnt <= '0;
      rx_bit_cnt  <= '0;
      rx_prev     <= 1'b1;
      rx_done     <= 1'b0;
    end else begin
      // Edge detect keeps running through a restart
      rx_prev <= rx;
      rx_done <= 1'b0;
      if (restart) begin
        rx_state    <= RX_IDLE;
        rx_tick_cnt <= '0;
        rx_bit_cnt  <= '0;
      end else begin
        case (rx_state)
          RX_IDLE: begin
            rx_tick_cnt <= '0;
            rx_bit_cnt  <= '0;
            // A line held low after a bad stop bit is not a new start
            if (rx_fall) begin
              rx_state <= RX_CHECK_START;
            end
          end
          RX_CHECK_START: begin
            if (rx_half) begin
              rx_tick_cnt <= '0;
              rx_state    <= rx ? RX_IDLE : RX_READING;
            end else if (tick) begin
              rx_tick_cnt <= rx_tick_cnt + 1'b1;
            end
          end
          RX_READING: begin
            if (rx_bit_end) begin
              rx_tick_cnt <= '0;
              if (rx_bit_cnt == bit_cnt_t'(7)) begin
                rx_state <= RX_CHECK_STOP;
              end else begin
                rx_bit_cnt <= rx_bit_cnt + 1'b1;
              end
            end else if (tick) begin
              rx_tick_cnt <= rx_tick_cnt + 1'b1;
            end
          end
          RX_CHECK_STOP: begin
            if (rx_bit_end) begin
              rx_done  <= 1'b1;
              rx_state <= RX_IDLE;
            end else if (tick) begin
              rx_tick_cnt <= rx_tick_cnt + 1'b1;
            end
          end
          default: rx_state <= RX_IDLE;
        endcase
      end
    end
  end

  // Mid-bit samples and the reported frame
  always_ff @(posedge clk) begin
    if (rx_state == RX_READING && rx_bit_end) begin
      rx_shift <= {rx, rx_shift[7:1]};
    end
    if (rx_state == RX_CHECK_STOP && rx_bit_end) begin
      result.data        <= rx_shift;
      result.frame_error <= !rx;
    end
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !tx_busy);

endmodule

`default_nettype wire

//--- design/tx_dispatch.sv
// Transmit command router with busy-lane rejection
`timescale 1ns/1ps
`default_nettype none

module tx_dispatch import uart_bank_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  tx_cmd_t    tx_cmd,
  input  lane_mask_t tx_busy,
  output lane_mask_t lane_start,
  output uart_byte_t lane_data,
  output logic       tx_reject
);

  lane_mask_t lane_sel;
  lane_mask_t lane_taken;

  // One-hot decode of the addressed lane
  assign lane_sel   = lane_mask_t'(1) << tx_cmd.lane;
  // A start still in flight counts as busy
  // The lane raises tx_busy a cycle later
  assign lane_taken = tx_busy | lane_start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_start <= '0;
      tx_reject  <= 1'b0;
    end else begin
      lane_start <= '0;
      tx_reject  <= 1'b0;
      if (tx_start) begin
        if ((lane_sel & lane_taken) != '0) begin
          tx_reject <= 1'b1;
        end else begin
          lane_start <= lane_sel;
        end
      end
    end
  end

  // Only the started lane picks up the shared data
  always_ff @(posedge clk) begin
    if (tx_start) begin
      lane_data <= tx_cmd.data;
    end
  end

  // A lane never gets starts in two cycles running
  a_no_double_start: assert property (@(posedge clk) disable iff (!rst_n)
    (lane_start & $past(lane_start)) == '0);

endmodule

`default_nettype wire

//--- design/baud_tick_gen.sv
// Loadable clock divider producing the shared 16x oversampling tick and restart pulse
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen import uart_bank_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       set_clock_div,
  input  clock_div_t user_clock_div,
  output logic       tick,
  output logic       restart
);

  clock_div_t clock_div;
  clock_div_t div_cnt;
  logic       wrap;

  // Last cycle of the divider period
  // A divider of 0 or 1 wraps every cycle
  assign wrap = ({1'b0, div_cnt} + 17'd1) >= {1'b0, clock_div};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clock_div <= clock_div_t'(DEFAULT_CLOCK_DIV);
      div_cnt   <= '0;
      tick      <= 1'b0;
      restart   <= 1'b0;
    end else begin
      // Announce a new divider one cycle after the load
      restart <= set_clock_div;
      if (set_clock_div) begin
        clock_div <= user_clock_div;
        div_cnt   <= '0;
        tick      <= 1'b0;
      end else if (wrap) begin
        div_cnt <= '0;
        tick    <= 1'b1;
      end else begin
        div_cnt <= div_cnt + 1'b1;
        tick    <= 1'b0;
      end
    end
  end

  // Tick is a single-cycle pulse unless the divider runs at every clock
  a_tick_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (tick && clock_div >= 16'd2) |=> !tick);

endmodule

`default_nettype wire

//--- design/uart_bank_pkg.sv
// Shared constants, width types, lane state encodings and bank command and event structs
`default_nettype none

package uart_bank_pkg;

  // Bank geometry
  localparam int NUM_LANES  = 4;
  localparam int LANE_IDX_W = 2;

  // Oversampling, ticks per bit and ticks to mid-start
  localparam int OVERSAMPLE = 16;
  localparam int HALF_BIT   = 8;
  localparam int STOP_BITS  = 1;

  // Clocking, default divider works out to 5
  localparam int CLOCK_RATE        = 10_000_000;
  localparam int DEFAULT_BAUDRATE  = 115_200;
  localparam int DEFAULT_CLOCK_DIV = CLOCK_RATE / (OVERSAMPLE * DEFAULT_BAUDRATE);

  typedef logic [7:0]            uart_byte_t;
  // Clk cycles per oversample tick
  typedef logic [15:0]           clock_div_t;
  typedef logic [LANE_IDX_W-1:0] lane_idx_t;
  typedef logic [NUM_LANES-1:0]  lane_mask_t;
  typedef logic [4:0]            tick_cnt_t;
  typedef logic [3:0]            bit_cnt_t;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
  typedef enum logic [1:0] {RX_IDLE, RX_CHECK_START, RX_READING, RX_CHECK_STOP} rx_state_e;

  // One transmit request
  typedef struct packed {
    lane_idx_t  lane;
    uart_byte_t data;
  } tx_cmd_t;

  // What one lane hands to the collector
  typedef struct packed {
    uart_byte_t data;
    logic       frame_error;
  } rx_result_t;

  // One receive event as seen outside the bank
  typedef struct packed {
    lane_idx_t  lane;
    uart_byte_t data;
    logic       frame_error;
    logic       overrun;
  } rx_event_t;

endpackage

`default_nettype wire
